//--- ks10MemPkg.sv
`default_nettype none

package ks10MemPkg;

   //////////////////////////////////////////////////
   // Bus words
   //////////////////////////////////////////////////

   // One 36-bit backplane word, PDP-10 bit order 0:35
   typedef logic [0:35] busWord;

   // Physical word address, low 20 bits of busADDRI
   typedef logic [16:35] memAddr;

   // Flag and address layout of busADDRI
   typedef struct packed {
      logic [0:2]   rsvd0;     // Unused flags
      logic         read;      // Read cycle
      logic         rsvd4;
      logic         write;     // Write cycle
      logic [6:9]   rsvd6;
      logic         io;        // I/O cycle, not a memory access
      logic [11:15] rsvd11;
      memAddr       addr;
   } busAddrFields;

   // Same word, raw as on the bus or split into flags and address
   typedef union packed {
      busWord       raw;
      busAddrFields fields;
   } busAddrWord;

   //////////////////////////////////////////////////
   // Pipeline stage words
   //////////////////////////////////////////////////

   // Decoded request, stage 1 to stage 2
   typedef struct packed {
      logic   valid;           // Memory cycle that will be acked
      logic   read;
      logic   write;
      memAddr addr;
      busWord data;            // Write data
   } memOp;

   // Array result, stage 2 to stage 3
   typedef struct packed {
      logic   valid;
      logic   read;
      busWord data;            // Word read before any write
   } memResp;

endpackage

`default_nettype wire

//--- memReqDecode.sv
`timescale 1ns/100ps
`default_nettype none

module memReqDecode #(
   parameter int unsigned memWords = 32768
) (
   input  wire logic                   clk,
   input  wire logic                   clken,
   input  wire logic                   rst,
   input  wire logic                   busREQI,
   input  wire ks10MemPkg::busAddrWord busADDRI,
   input  wire ks10MemPkg::busWord     busDATAI,
   output ks10MemPkg::memOp            opDec
);

   //////////////////////////////////////////////////
   // Field decode of the address word
   //////////////////////////////////////////////////

   // Address and flags taken through the fields view
   ks10MemPkg::memAddr reqAddr;
   logic               reqRead;
   logic               reqWrite;
   logic               reqIO;

   // Range check and final accept
   logic               inRange;
   logic               reqValid;

   assign reqAddr  = busADDRI.fields.addr;
   assign reqRead  = busADDRI.fields.read;
   assign reqWrite = busADDRI.fields.write;
   assign reqIO    = busADDRI.fields.io;

   // Only the first memWords words exist
   assign inRange  = 32'(reqAddr) < memWords;

   // I/O cycles belong to the I/O bus, never to memory
   // Out of range addresses are left for nobody to ack
   assign reqValid = busREQI & ~reqIO & inRange;

   //////////////////////////////////////////////////
   // Stage 1 register
   //////////////////////////////////////////////////

   // Control bit
   logic               validQ;

   // Request payload
   logic               readQ;
   logic               writeQ;
   ks10MemPkg::memAddr addrQ;
   ks10MemPkg::busWord dataQ;

   // Valid cleared by reset, else follows accepted strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         validQ <= 1'b0;
      end else if (clken) begin
         validQ <= reqValid;
      end
   end

   // Payload just rides along with valid
   always_ff @(posedge clk) begin
      if (clken) begin
         readQ  <= reqRead;
         writeQ <= reqWrite;
         addrQ  <= reqAddr;
         dataQ  <= busDATAI;
      end
   end

   // Both flags set is read-pause-write, handled by the array
   assign opDec = '{
      valid: validQ,
      read:  readQ,
      write: writeQ,
      addr:  addrQ,
      data:  dataQ
   };

endmodule

`default_nettype wire

//--- memArray.sv
`timescale 1ns/100ps
`default_nettype none

module memArray #(
   parameter int unsigned memWords = 32768
) (
   input  wire logic             clk,
   input  wire logic             clken,
   input  wire logic             rst,
   input  wire ks10MemPkg::memOp opDec,
   output ks10MemPkg::memResp    respMem
);

   //////////////////////////////////////////////////
   // Array geometry
   //////////////////////////////////////////////////

   // Index width from the implemented size, at least one bit
   localparam int idxBits = (memWords > 1) ? $clog2(memWords) : 1;

   // Word index, low bits of the 20-bit address
   // Upper bits are known zero once stage 1 passed the range check
   logic [idxBits-1:0] wordIdx;

   assign wordIdx = opDec.addr[36-idxBits:35];

   // Storage, no reset on the array itself
   ks10MemPkg::busWord memory [memWords];

   //////////////////////////////////////////////////
   // Stage 2 access
   //////////////////////////////////////////////////

   // Control bit
   logic               validQ;

   // Result payload
   logic               readQ;
   ks10MemPkg::busWord rdData;

   always_ff @(posedge clk) begin
      if (rst) begin
         validQ <= 1'b0;
      end else if (clken) begin
         validQ <= opDec.valid;
      end
   end

   // Read before write at the same edge
   // Old word is sampled while the new one is stored
   // so read-pause-write returns previous contents
   always_ff @(posedge clk) begin
      if (clken) begin
         readQ <= opDec.read;
         if (opDec.valid) begin
            rdData <= memory[wordIdx];
            if (opDec.write) begin
               memory[wordIdx] <= opDec.data;
            end
         end
      end
   end

   // Read data held from last access on idle slots
   assign respMem = '{
      valid: validQ,
      read:  readQ,
      data:  rdData
   };

endmodule

`default_nettype wire

//--- memResponse.sv
`timescale 1ns/100ps
`default_nettype none

module memResponse (
   input  wire logic               clk,
   input  wire logic               clken,
   input  wire logic               rst,
   input  wire ks10MemPkg::memResp respMem,
   output logic                    busACKO,
   output ks10MemPkg::busWord      busDATAO
);

   //////////////////////////////////////////////////
   // Stage 3 bus reply
   //////////////////////////////////////////////////

   // Read data worth putting on the bus
   logic rdReturn;

   assign rdReturn = respMem.valid & respMem.read;

   // Ack is a one slot level per accepted request
   always_ff @(posedge clk) begin
      if (rst) begin
         busACKO <= 1'b0;
      end else if (clken) begin
         busACKO <= respMem.valid;
      end
   end

   // Data word changes only when a read comes back
   // Writes and unacked slots leave the last read word
   always_ff @(posedge clk) begin
      if (rst) begin
         busDATAO <= '0;
      end else if (clken && rdReturn) begin
         busDATAO <= respMem.data;
      end
   end

endmodule

`default_nettype wire

//--- ks10Mem.sv
`timescale 1ns/100ps
`default_nettype none

module ks10Mem #(
   parameter int unsigned memWords = 32768
) (
   input  wire logic                   clk,
   input  wire logic                   clken,
   input  wire logic                   rst,
   input  wire logic                   busREQI,
   input  wire ks10MemPkg::busAddrWord busADDRI,
   input  wire ks10MemPkg::busWord     busDATAI,
   output logic                        busACKO,
   output ks10MemPkg::busWord          busDATAO
);

   //////////////////////////////////////////////////
   // Stage to stage words
   //////////////////////////////////////////////////

   // Decoded request into the array
   wire ks10MemPkg::memOp   opDec;

   // Array result into the bus reply
   wire ks10MemPkg::memResp respMem;

   //////////////////////////////////////////////////
   // Pipeline
   //////////////////////////////////////////////////

   // Stage 1, flag decode and range check
   memReqDecode #(
      .memWords (memWords)
   ) i_memReqDecode (
      .clk      (clk),
      .clken    (clken),
      .rst      (rst),
      .busREQI  (busREQI),
      .busADDRI (busADDRI),
      .busDATAI (busDATAI),
      .opDec    (opDec)
   );

   // Stage 2, on-chip array in place of the SSRAM
   memArray #(
      .memWords (memWords)
   ) i_memArray (
      .clk     (clk),
      .clken   (clken),
      .rst     (rst),
      .opDec   (opDec),
      .respMem (respMem)
   );

   // Stage 3, registered ack and data
   memResponse i_memResponse (
      .clk      (clk),
      .clken    (clken),
      .rst      (rst),
      .respMem  (respMem),
      .busACKO  (busACKO),
      .busDATAO (busDATAO)
   );

endmodule

`default_nettype wire

//--- ks10MemTb.sv
`timescale 1ns/100ps
`default_nettype none

module ks10MemTb;

   //////////////////////////////////////////////////
   // Run limits
   //////////////////////////////////////////////////

   localparam int resetCycles = 4;
   localparam int maxVectors  = 128;
   localparam int cycleMargin = 20;

   // Reply owed by the DUT at a given enabled edge
   typedef struct packed {
      logic [31:0] due;
      logic        ack;
      logic        chk;
      logic [35:0] data;
   } expectEntry;

   // DUT ports
   logic                   clk;
   logic                   clken;
   logic                   rst;
   logic                   busREQI;
   ks10MemPkg::busAddrWord busADDRI;
   ks10MemPkg::busWord     busDATAI;
   logic                   busACKO;
   ks10MemPkg::busWord     busDATAO;

   // Golden vectors, 120 bits per line
   // [119:116] ctrl, [115:80] addr, [79:44] wdata, [43:40] ack, [39:36] chk, [35:0] rdata
   logic [119:0] vectors [maxVectors];
   int           vecCount;

   // Replies in flight, at most a few deep
   expectEntry   pending [$];
   int unsigned  edgeCount;
   int unsigned  cycleCount;
   int unsigned  cycleLimit;
   int           errorCount;
   int           checkCount;
   integer       seed;

   // Outputs as left by the last enabled edge
   logic               heldAck;
   ks10MemPkg::busWord heldData;

   ks10Mem i_ks10Mem (
      .clk      (clk),
      .clken    (clken),
      .rst      (rst),
      .busREQI  (busREQI),
      .busADDRI (busADDRI),
      .busDATAI (busDATAI),
      .busACKO  (busACKO),
      .busDATAO (busDATAO)
   );

   // 10 ns clock
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Hard stop if the DUT or the run stalls
   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
         $display("Timeout: the run took more than %0d clock cycles", cycleLimit);
         $display("Checks: %0d, errors: %0d", checkCount, errorCount);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Output checks
   //////////////////////////////////////////////////

   task automatic checkAck(input logic expAck, input string what);
      checkCount++;
      assert (busACKO === expAck) else begin
         $display("FAILED busACKO %s: expected %h, got %h", what, expAck, busACKO);
         errorCount++;
      end
   endtask

   task automatic checkData(input logic [35:0] expData, input string what);
      checkCount++;
      assert (busDATAO === expData) else begin
         $display("FAILED busDATAO %s: expected %h, got %h", what, expData, busDATAO);
         errorCount++;
      end
   endtask

   // Match the edge just past against the reply list
   task automatic checkEdge();
      int         hit;
      int         j;
      expectEntry e;
      string      where;
      hit   = -1;
      where = $sformatf("at enabled edge %0d", edgeCount);
      for (j = 0; j < pending.size(); j++) begin
         if (pending[j].due == edgeCount) begin
            hit = j;
         end
      end
      if (hit < 0) begin
         // Nothing owed, right after reset or once drained
         checkAck(1'b0, where);
      end else begin
         e = pending[hit];
         pending.delete(hit);
         checkAck(e.ack, where);
         if (e.chk) begin
            checkData(e.data, where);
         end
      end
      heldAck  = busACKO;
      heldData = busDATAO;
   endtask

   // Outputs frozen while clken is low
   task automatic checkHold();
      checkAck(heldAck, "while clken low");
      checkData(heldData, "while clken low");
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   // Called at a falling edge with inputs already set
   task automatic runCycle(input logic en);
      clken = en;
      @(negedge clk);
      if (en) begin
         edgeCount++;
         checkEdge();
      end else begin
         checkHold();
      end
   endtask

   task automatic driveVector(input logic [119:0] v);
      expectEntry e;
      busREQI      = v[116];
      busADDRI.raw = v[115:80];
      busDATAI     = v[79:44];
      // Sampled at the next enabled edge, reply after the third one from now
      e.due  = edgeCount + 3;
      e.ack  = v[40];
      e.chk  = v[36];
      e.data = v[35:0];
      pending.push_back(e);
      runCycle(1'b1);
   endtask

   task automatic idleCycles(input int unsigned n);
      // Strobe left high, must be ignored without clken
      busREQI = 1'b1;
      repeat (n) runCycle(1'b0);
   endtask

   initial begin
      int          i;
      int unsigned idle;
      clken        = 1'b0;
      rst          = 1'b1;
      busREQI      = 1'b0;
      busADDRI.raw = '0;
      busDATAI     = '0;
      edgeCount    = 0;
      cycleCount   = 0;
      cycleLimit   = 0;
      errorCount   = 0;
      checkCount   = 0;
      heldAck      = 1'b0;
      heldData     = '0;
      seed         = 32'hce2a6b16;

      // All ones marks lines not in the file
      for (i = 0; i < maxVectors; i++) begin
         vectors[i] = '1;
      end
      $readmemh("ks10MemGolden.txt", vectors);
      vecCount = 0;
      while (vecCount < maxVectors && vectors[vecCount] != '1) begin
         vecCount++;
      end
      if (vecCount == 0) begin
         $display("No vectors could be read from ks10MemGolden.txt");
         errorCount++;
      end
      // Worst case four cycles per vector, plus drain
      cycleLimit = (vecCount + 3) * 4 + resetCycles + cycleMargin;

      // Reset with clken low
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      checkAck(1'b0, "after reset");
      checkData('0, "after reset");

      for (i = 0; i < vecCount; i++) begin
         driveVector(vectors[i]);
         // Ctrl bit 1 puts the next vector on the very next cycle
         if (!vectors[i][117]) begin
            idle = $unsigned($random(seed)) % 4;
            idleCycles(idle);
         end
      end

      // Drain the pipeline, last edge must show no ack
      busREQI = 1'b0;
      repeat (3) runCycle(1'b1);
      if (pending.size() != 0) begin
         $display("Replies still owed at the end of the run: %0d", pending.size());
         errorCount++;
      end

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- ks10MemGolden.txt
// ctrl_addr_wdata_ack_chk_rdata; ctrl bit0 busREQI, bit1 next vector with no idle cycles
// addr word flags: 1........ read, .4....... write, ..2...... io; memWords is 08000
// Write several words, including the first and last implemented address
1_040000000_123456789_1_1_000000000
1_040000001_0DEADBEEF_1_0_000000000
1_040001234_7654321AB_1_0_000000000
1_040007FFF_FFFFFFFFF_1_0_000000000
1_040004000_555555555_1_0_000000000
// Read them back
1_100000000_000000000_1_1_123456789
1_100000001_000000000_1_1_0DEADBEEF
1_100001234_000000000_1_1_7654321AB
1_100007FFF_000000000_1_1_FFFFFFFFF
1_100004000_000000000_1_1_555555555
// Out of range, no ack and data held
1_040008000_0BADBAD00_0_0_000000000
1_100008000_000000000_0_1_555555555
1_0400FFFFF_111111111_0_0_000000000
1_1000FFFFF_000000000_0_1_555555555
1_100000000_000000000_1_1_123456789
1_040018000_222222222_0_0_000000000
1_100000000_000000000_1_1_123456789
// I/O cycles, never acked, memory untouched
1_042000001_333333333_0_0_000000000
1_102000001_000000000_0_1_123456789
1_100000001_000000000_1_1_0DEADBEEF
1_142007FFF_444444444_0_0_000000000
1_100007FFF_000000000_1_1_FFFFFFFFF
// Read-pause-write returns the old word
1_140001234_0A5A5A5A5_1_1_7654321AB
1_100001234_000000000_1_1_0A5A5A5A5
1_140000000_0000000FF_1_1_123456789
1_100000000_000000000_1_1_0000000FF
// Back to back on one address
3_040002000_135792468_1_0_000000000
3_100002000_000000000_1_1_135792468
3_040002000_2468ACE02_1_1_135792468
3_100002000_000000000_1_1_2468ACE02
3_140002000_0F0F0F0F0_1_1_2468ACE02
1_100002000_000000000_1_1_0F0F0F0F0
// Enabled cycles without a request
0_000000000_000000000_0_1_0F0F0F0F0
0_100000000_000000000_0_1_0F0F0F0F0
// Mixed traffic
1_100004000_000000000_1_1_555555555
1_040007FFF_0CAFEF00D_1_0_000000000
3_100007FFF_000000000_1_1_0CAFEF00D
3_100000001_000000000_1_1_0DEADBEEF
1_100004000_000000000_1_1_555555555
// Request with neither flag is acked, data held
1_000000000_000000000_1_1_555555555
1_100000000_000000000_1_1_0000000FF
1_100008001_000000000_0_1_0000000FF
1_100007FFF_000000000_1_1_0CAFEF00D

//--- tb.f
ks10MemPkg.sv
memReqDecode.sv
memArray.sv
memResponse.sv
ks10Mem.sv
ks10MemTb.sv

//--- Makefile
# Verilator flow for the KS-10 memory pipeline

TOP = ks10MemTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

# Pass only if the testbench printed the pass line
run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

lint:
	verilator --lint-only --top-module ks10Mem \
		ks10MemPkg.sv memReqDecode.sv memArray.sv memResponse.sv ks10Mem.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir
